/* Bender.yml */
package:
  name: soc_bus_wrap

sources:
  # Package first, then the RTL in dependency order
  - common/soc_pkg.sv
  - interconnect/wb_xbar.sv
  - apb_bridge/wb_apb_bridge.sv
  - hdl/soc_bus_wrap.sv

  - target: test
    files:
      - verification/tb_target_models.sv
      - verification/tb_soc_bus_wrap.sv

/* apb_bridge/wb_apb_bridge.sv */
// ------------------------------------------------
// Wishbone to APB bridge, 64-bit classic cycles to
// 32-bit APB setup and access phases
// ------------------------------------------------
`default_nettype none

module wb_apb_bridge (
   input  logic               clk,
   input  logic               rst_n_i,
   // Wishbone slave
   input  logic               wb_cyc_i,
   input  logic               wb_stb_i,
   input  logic               wb_we_i,
   input  soc_pkg::addr_t     wb_adr_i,
   input  soc_pkg::data_t     wb_dat_i,
   output soc_pkg::data_t     wb_dat_o,
   output logic               wb_ack_o,
   output logic               wb_err_o,
   // APB master
   output logic               psel_o,
   output logic               penable_o,
   output logic               pwrite_o,
   output soc_pkg::apb_addr_t paddr_o,
   output soc_pkg::apb_data_t pwdata_o,
   input  soc_pkg::apb_data_t prdata_i,
   input  logic               pready_i,
   input  logic               pslverr_i
);

   typedef enum logic [1:0] {
      IDLE   = 2'd0,
      SETUP  = 2'd1,
      ACCESS = 2'd2,
      RESP   = 2'd3
   } state_e;

   state_e             state_q;
   state_e             state_d;
   logic               start;
   logic               pwrite_q;
   logic               lane_hi_q;
   soc_pkg::apb_addr_t paddr_q;
   soc_pkg::apb_data_t pwdata_q;
   soc_pkg::apb_data_t prdata_q;
   logic               slverr_q;

   assign start = wb_cyc_i & wb_stb_i;

   // ------------------------------------------------
   // Transfer sequencing
   // ------------------------------------------------
   always_comb begin
      state_d = state_q;
      unique case (state_q)
         IDLE: begin
            if (start) begin
               state_d = SETUP;
            end
         end
         SETUP: begin
            state_d = ACCESS;
         end
         ACCESS: begin
            if (pready_i) begin
               state_d = RESP;
            end
         end
         default: begin
            state_d = IDLE;
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rst_n_i) begin
         state_q <= IDLE;
      end else begin
         state_q <= state_d;
      end
   end

   // Request capture and APB completion
   always_ff @(posedge clk) begin
      if (state_q == IDLE && start) begin
         paddr_q   <= wb_adr_i[soc_pkg::ApbAddrWidth-1:0];
         pwrite_q  <= wb_we_i;
         lane_hi_q <= wb_adr_i[2];
         pwdata_q  <= wb_adr_i[2] ? wb_dat_i[soc_pkg::DataWidth-1:soc_pkg::ApbDataWidth]
                                  : wb_dat_i[soc_pkg::ApbDataWidth-1:0];
      end
      if (state_q == ACCESS && pready_i) begin
         prdata_q <= prdata_i;
         slverr_q <= pslverr_i;
      end
   end

   // ------------------------------------------------
   // Outputs
   // ------------------------------------------------
   assign psel_o    = (state_q == SETUP) || (state_q == ACCESS);
   assign penable_o = (state_q == ACCESS);
   assign pwrite_o  = pwrite_q;
   assign paddr_o   = paddr_q;
   assign pwdata_o  = pwdata_q;

   assign wb_ack_o = (state_q == RESP) && !slverr_q;
   assign wb_err_o = (state_q == RESP) && slverr_q;

   // Read data in the lane picked by address bit 2
   assign wb_dat_o = lane_hi_q ? {prdata_q, {soc_pkg::ApbDataWidth{1'b0}}}
                               : {{soc_pkg::ApbDataWidth{1'b0}}, prdata_q};

endmodule

`default_nettype wire

/* common/soc_pkg.sv */
// ------------------------------------------------
// System bus definitions: address map, bus widths
// and target indices for the bus wrapper
// ------------------------------------------------
`default_nettype none

package soc_pkg;

   // Bus widths
   localparam int unsigned AddrWidth    = 64;
   localparam int unsigned DataWidth    = 64;
   localparam int unsigned SelWidth     = DataWidth / 8;
   localparam int unsigned ApbAddrWidth = 32;
   localparam int unsigned ApbDataWidth = 32;

   typedef logic [AddrWidth-1:0]    addr_t;
   typedef logic [DataWidth-1:0]    data_t;
   typedef logic [SelWidth-1:0]     sel_t;
   typedef logic [ApbAddrWidth-1:0] apb_addr_t;
   typedef logic [ApbDataWidth-1:0] apb_data_t;

   // ------------------------------------------------
   // Targets
   // ------------------------------------------------
   typedef enum int unsigned {
      ROM   = 0,
      APB   = 1,
      CLINT = 2,
      SLM   = 3,
      DRAM  = 4
   } slave_idx_e;

   localparam int unsigned NrSlaves = 5;

   // External memory-style ports, APB excluded
   typedef enum int unsigned {
      MEM_ROM   = 0,
      MEM_CLINT = 1,
      MEM_SLM   = 2,
      MEM_DRAM  = 3
   } mem_idx_e;

   localparam int unsigned NrMemPorts = 4;

   // Address map in slave_idx_e order
   localparam addr_t SlaveBase [NrSlaves] = '{
      64'h0000_0000_0001_0000,
      64'h0000_0000_6000_0000,
      64'h0000_0000_0200_0000,
      64'h0000_0000_0400_0000,
      64'h0000_0000_8000_0000
   };

   localparam addr_t SlaveLength [NrSlaves] = '{
      64'h0000_0000_0001_0000,
      64'h0000_0000_1000_0000,
      64'h0000_0000_000C_0000,
      64'h0000_0000_0400_0000,
      64'h0000_0000_2000_0000
   };

endpackage

`default_nettype wire

/* hdl/soc_bus_wrap.sv */
// ------------------------------------------------
// System bus wrapper: host port, crossbar, APB bridge
// and the external memory target ports
// ------------------------------------------------
`default_nettype none

module soc_bus_wrap (
   input  logic                           clk,
   input  logic                           rst_n_i,
   // Host port
   input  logic                           host_cyc_i,
   input  logic                           host_stb_i,
   input  logic                           host_we_i,
   input  soc_pkg::addr_t                 host_adr_i,
   input  soc_pkg::data_t                 host_dat_i,
   input  soc_pkg::sel_t                  host_sel_i,
   output soc_pkg::data_t                 host_dat_o,
   output logic                           host_ack_o,
   output logic                           host_err_o,
   // Memory targets, mem_idx_e order
   output logic [soc_pkg::NrMemPorts-1:0] mem_cyc_o,
   output logic [soc_pkg::NrMemPorts-1:0] mem_stb_o,
   output logic                           mem_we_o,
   output soc_pkg::addr_t                 mem_adr_o,
   output soc_pkg::data_t                 mem_dat_o,
   output soc_pkg::sel_t                  mem_sel_o,
   input  soc_pkg::data_t                 mem_dat_i [soc_pkg::NrMemPorts],
   input  logic [soc_pkg::NrMemPorts-1:0] mem_ack_i,
   input  logic [soc_pkg::NrMemPorts-1:0] mem_err_i,
   // APB
   output logic                           psel_o,
   output logic                           penable_o,
   output logic                           pwrite_o,
   output soc_pkg::apb_addr_t             paddr_o,
   output soc_pkg::apb_data_t             pwdata_o,
   input  soc_pkg::apb_data_t             prdata_i,
   input  logic                           pready_i,
   input  logic                           pslverr_i
);

   logic [soc_pkg::NrSlaves-1:0]      tgt_cyc;
   logic [soc_pkg::NrSlaves-1:0]      tgt_stb;
   logic                              tgt_we;
   soc_pkg::addr_t                    tgt_adr;
   soc_pkg::data_t                    tgt_dat;
   soc_pkg::sel_t                     tgt_sel;
   wire soc_pkg::data_t               tgt_rdat [soc_pkg::NrSlaves];
   wire logic [soc_pkg::NrSlaves-1:0] tgt_ack;
   wire logic [soc_pkg::NrSlaves-1:0] tgt_err;

   // ------------------------------------------------
   // Crossbar
   // ------------------------------------------------
   wb_xbar i_wb_xbar (
      .clk        ( clk        ),
      .rst_n_i    ( rst_n_i    ),
      .host_cyc_i ( host_cyc_i ),
      .host_stb_i ( host_stb_i ),
      .host_we_i  ( host_we_i  ),
      .host_adr_i ( host_adr_i ),
      .host_dat_i ( host_dat_i ),
      .host_sel_i ( host_sel_i ),
      .host_dat_o ( host_dat_o ),
      .host_ack_o ( host_ack_o ),
      .host_err_o ( host_err_o ),
      .tgt_cyc_o  ( tgt_cyc    ),
      .tgt_stb_o  ( tgt_stb    ),
      .tgt_we_o   ( tgt_we     ),
      .tgt_adr_o  ( tgt_adr    ),
      .tgt_dat_o  ( tgt_dat    ),
      .tgt_sel_o  ( tgt_sel    ),
      .tgt_dat_i  ( tgt_rdat   ),
      .tgt_ack_i  ( tgt_ack    ),
      .tgt_err_i  ( tgt_err    )
   );

   // ------------------------------------------------
   // APB slot
   // ------------------------------------------------
   wb_apb_bridge i_wb_apb_bridge (
      .clk       ( clk                    ),
      .rst_n_i   ( rst_n_i                ),
      .wb_cyc_i  ( tgt_cyc[soc_pkg::APB]  ),
      .wb_stb_i  ( tgt_stb[soc_pkg::APB]  ),
      .wb_we_i   ( tgt_we                 ),
      .wb_adr_i  ( tgt_adr                ),
      .wb_dat_i  ( tgt_dat                ),
      .wb_dat_o  ( tgt_rdat[soc_pkg::APB] ),
      .wb_ack_o  ( tgt_ack[soc_pkg::APB]  ),
      .wb_err_o  ( tgt_err[soc_pkg::APB]  ),
      .psel_o    ( psel_o                 ),
      .penable_o ( penable_o              ),
      .pwrite_o  ( pwrite_o               ),
      .paddr_o   ( paddr_o                ),
      .pwdata_o  ( pwdata_o               ),
      .prdata_i  ( prdata_i               ),
      .pready_i  ( pready_i               ),
      .pslverr_i ( pslverr_i              )
   );

   // ------------------------------------------------
   // Memory slots, slave_idx_e to mem_idx_e
   // ------------------------------------------------
   assign mem_we_o  = tgt_we;
   assign mem_adr_o = tgt_adr;
   assign mem_dat_o = tgt_dat;
   assign mem_sel_o = tgt_sel;

   assign mem_cyc_o[soc_pkg::MEM_ROM]   = tgt_cyc[soc_pkg::ROM];
   assign mem_cyc_o[soc_pkg::MEM_CLINT] = tgt_cyc[soc_pkg::CLINT];
   assign mem_cyc_o[soc_pkg::MEM_SLM]   = tgt_cyc[soc_pkg::SLM];
   assign mem_cyc_o[soc_pkg::MEM_DRAM]  = tgt_cyc[soc_pkg::DRAM];

   assign mem_stb_o[soc_pkg::MEM_ROM]   = tgt_stb[soc_pkg::ROM];
   assign mem_stb_o[soc_pkg::MEM_CLINT] = tgt_stb[soc_pkg::CLINT];
   assign mem_stb_o[soc_pkg::MEM_SLM]   = tgt_stb[soc_pkg::SLM];
   assign mem_stb_o[soc_pkg::MEM_DRAM]  = tgt_stb[soc_pkg::DRAM];

   // Responses back into crossbar order
   assign tgt_rdat[soc_pkg::ROM]   = mem_dat_i[soc_pkg::MEM_ROM];
   assign tgt_rdat[soc_pkg::CLINT] = mem_dat_i[soc_pkg::MEM_CLINT];
   assign tgt_rdat[soc_pkg::SLM]   = mem_dat_i[soc_pkg::MEM_SLM];
   assign tgt_rdat[soc_pkg::DRAM]  = mem_dat_i[soc_pkg::MEM_DRAM];

   assign tgt_ack[soc_pkg::ROM]   = mem_ack_i[soc_pkg::MEM_ROM];
   assign tgt_ack[soc_pkg::CLINT] = mem_ack_i[soc_pkg::MEM_CLINT];
   assign tgt_ack[soc_pkg::SLM]   = mem_ack_i[soc_pkg::MEM_SLM];
   assign tgt_ack[soc_pkg::DRAM]  = mem_ack_i[soc_pkg::MEM_DRAM];

   assign tgt_err[soc_pkg::ROM]   = mem_err_i[soc_pkg::MEM_ROM];
   assign tgt_err[soc_pkg::CLINT] = mem_err_i[soc_pkg::MEM_CLINT];
   assign tgt_err[soc_pkg::SLM]   = mem_err_i[soc_pkg::MEM_SLM];
   assign tgt_err[soc_pkg::DRAM]  = mem_err_i[soc_pkg::MEM_DRAM];

endmodule

`default_nettype wire

/* interconnect/wb_xbar.sv */
// ------------------------------------------------
// Wishbone crossbar: decodes the host address to one
// target, routes the cycle and errors unmapped ones
// ------------------------------------------------
`default_nettype none

module wb_xbar (
   input  logic                         clk,
   input  logic                         rst_n_i,
   // Host port
   input  logic                         host_cyc_i,
   input  logic                         host_stb_i,
   input  logic                         host_we_i,
   input  soc_pkg::addr_t               host_adr_i,
   input  soc_pkg::data_t               host_dat_i,
   input  soc_pkg::sel_t                host_sel_i,
   output soc_pkg::data_t               host_dat_o,
   output logic                         host_ack_o,
   output logic                         host_err_o,
   // Target ports
   output logic [soc_pkg::NrSlaves-1:0] tgt_cyc_o,
   output logic [soc_pkg::NrSlaves-1:0] tgt_stb_o,
   output logic                         tgt_we_o,
   output soc_pkg::addr_t               tgt_adr_o,
   output soc_pkg::data_t               tgt_dat_o,
   output soc_pkg::sel_t                tgt_sel_o,
   input  soc_pkg::data_t               tgt_dat_i [soc_pkg::NrSlaves],
   input  logic [soc_pkg::NrSlaves-1:0] tgt_ack_i,
   input  logic [soc_pkg::NrSlaves-1:0] tgt_err_i
);

   logic [soc_pkg::NrSlaves-1:0] hit;
   logic                         mapped;
   logic                         req;
   logic                         unmapped_err_q;

   assign req = host_cyc_i & host_stb_i;

   // ------------------------------------------------
   // Address decode
   // ------------------------------------------------
   // Ranges do not overlap, so hit is one-hot or zero
   always_comb begin
      for (int i = 0; i < soc_pkg::NrSlaves; i++) begin
         hit[i] = (host_adr_i >= soc_pkg::SlaveBase[i]) &&
                  (host_adr_i < soc_pkg::SlaveBase[i] + soc_pkg::SlaveLength[i]);
      end
   end

   assign mapped = |hit;

   // ------------------------------------------------
   // Request path
   // ------------------------------------------------
   assign tgt_cyc_o = host_cyc_i ? hit : '0;
   assign tgt_stb_o = req ? hit : '0;

   // Shared by all targets
   assign tgt_we_o  = host_we_i;
   assign tgt_adr_o = host_adr_i;
   assign tgt_dat_o = host_dat_i;
   assign tgt_sel_o = host_sel_i;

   // ------------------------------------------------
   // Response path
   // ------------------------------------------------
   always_comb begin
      host_dat_o = '0;
      host_ack_o = 1'b0;
      host_err_o = unmapped_err_q;
      for (int i = 0; i < soc_pkg::NrSlaves; i++) begin
         if (hit[i] && host_cyc_i) begin
            host_dat_o = tgt_dat_i[i];
            host_ack_o = tgt_ack_i[i];
            host_err_o = unmapped_err_q | tgt_err_i[i];
         end
      end
   end

   // Single error pulse for an access outside the map,
   // the master drops stb on the edge after it
   always_ff @(posedge clk) begin
      if (!rst_n_i) begin
         unmapped_err_q <= 1'b0;
      end else begin
         unmapped_err_q <= req && !mapped && !unmapped_err_q;
      end
   end

endmodule

`default_nettype wire

/* project.f */
common/soc_pkg.sv
interconnect/wb_xbar.sv
apb_bridge/wb_apb_bridge.sv
hdl/soc_bus_wrap.sv
verification/tb_target_models.sv
verification/tb_soc_bus_wrap.sv

/* verification/tb_soc_bus_wrap.sv */
// ------------------------------------------------
// Testbench for the system bus wrapper with directed
// tests over memory, APB and unmapped targets
// ------------------------------------------------
`default_nettype none

module tb_soc_bus_wrap;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int ClkPeriod   = 20;
   localparam int ResetCycles = 10;
   localparam int NrTests     = 6;
   localparam int WorstCycles = 120;
   localparam int MaxWait     = 16;

   logic                           clk = 1'b0;
   logic                           rst_n_i;
   logic                           host_cyc_i;
   logic                           host_stb_i;
   logic                           host_we_i;
   soc_pkg::addr_t                 host_adr_i;
   soc_pkg::data_t                 host_dat_i;
   soc_pkg::sel_t                  host_sel_i;
   soc_pkg::data_t                 host_dat_o;
   logic                           host_ack_o;
   logic                           host_err_o;
   logic [soc_pkg::NrMemPorts-1:0] mem_cyc_o;
   logic [soc_pkg::NrMemPorts-1:0] mem_stb_o;
   logic                           mem_we_o;
   soc_pkg::addr_t                 mem_adr_o;
   soc_pkg::data_t                 mem_dat_o;
   soc_pkg::sel_t                  mem_sel_o;
   soc_pkg::data_t                 mem_rdat [soc_pkg::NrMemPorts];
   logic [soc_pkg::NrMemPorts-1:0] mem_ack;
   logic [soc_pkg::NrMemPorts-1:0] mem_err;
   logic                           psel_o;
   logic                           penable_o;
   logic                           pwrite_o;
   soc_pkg::apb_addr_t             paddr_o;
   soc_pkg::apb_data_t             pwdata_o;
   soc_pkg::apb_data_t             prdata;
   logic                           pready;
   logic                           pslverr;

   logic [31:0]        lfsr_q = 32'hea3c;
   logic               apb_seen;
   soc_pkg::apb_addr_t apb_addr_seen;
   soc_pkg::apb_data_t apb_wdata_seen;
   soc_pkg::apb_data_t apb_lo_word;
   soc_pkg::apb_data_t apb_hi_word;

   soc_bus_wrap soc_bus_wrap_i (
      .clk        ( clk        ),
      .rst_n_i    ( rst_n_i    ),
      .host_cyc_i ( host_cyc_i ),
      .host_stb_i ( host_stb_i ),
      .host_we_i  ( host_we_i  ),
      .host_adr_i ( host_adr_i ),
      .host_dat_i ( host_dat_i ),
      .host_sel_i ( host_sel_i ),
      .host_dat_o ( host_dat_o ),
      .host_ack_o ( host_ack_o ),
      .host_err_o ( host_err_o ),
      .mem_cyc_o  ( mem_cyc_o  ),
      .mem_stb_o  ( mem_stb_o  ),
      .mem_we_o   ( mem_we_o   ),
      .mem_adr_o  ( mem_adr_o  ),
      .mem_dat_o  ( mem_dat_o  ),
      .mem_sel_o  ( mem_sel_o  ),
      .mem_dat_i  ( mem_rdat   ),
      .mem_ack_i  ( mem_ack    ),
      .mem_err_i  ( mem_err    ),
      .psel_o     ( psel_o     ),
      .penable_o  ( penable_o  ),
      .pwrite_o   ( pwrite_o   ),
      .paddr_o    ( paddr_o    ),
      .pwdata_o   ( pwdata_o   ),
      .prdata_i   ( prdata     ),
      .pready_i   ( pready     ),
      .pslverr_i  ( pslverr    )
   );

   tb_target_models models_i (
      .clk       ( clk       ),
      .mem_cyc_i ( mem_cyc_o ),
      .mem_stb_i ( mem_stb_o ),
      .mem_we_i  ( mem_we_o  ),
      .mem_adr_i ( mem_adr_o ),
      .mem_dat_i ( mem_dat_o ),
      .mem_sel_i ( mem_sel_o ),
      .mem_dat_o ( mem_rdat  ),
      .mem_ack_o ( mem_ack   ),
      .mem_err_o ( mem_err   ),
      .psel_i    ( psel_o    ),
      .penable_i ( penable_o ),
      .pwrite_i  ( pwrite_o  ),
      .paddr_i   ( paddr_o   ),
      .pwdata_i  ( pwdata_o  ),
      .prdata_o  ( prdata    ),
      .pready_o  ( pready    ),
      .pslverr_o ( pslverr   )
   );

   initial begin
      forever #(ClkPeriod / 2) clk = ~clk;
   end

   // ------------------------------------------------
   // Helpers
   // ------------------------------------------------
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] r;
      logic        fb;
      r = '0;
      for (int i = 0; i < n; i++) begin
         fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
         lfsr_q = {lfsr_q[30:0], fb};
         r = {r[30:0], fb};
      end
      return r;
   endfunction

   task automatic fail_run(input string what);
      $display("%s", what);
      $display("SIMULATION FAILED");
      $fatal(1, "Stopping at first error");
   endtask

   task automatic check_data(input string test, input soc_pkg::data_t exp,
                             input soc_pkg::data_t act);
      if (act !== exp) begin
         fail_run($sformatf("[FAIL] %s: expected %h, actual %h", test, exp, act));
      end
   endtask

   task automatic check_addr(input string test, input soc_pkg::addr_t exp,
                             input soc_pkg::addr_t act);
      if (act !== exp) begin
         fail_run($sformatf("[FAIL] %s: expected %h, actual %h", test, exp, act));
      end
   endtask

   task automatic check_sel(input string test, input soc_pkg::sel_t exp,
                            input soc_pkg::sel_t act);
      if (act !== exp) begin
         fail_run($sformatf("[FAIL] %s: expected %h, actual %h", test, exp, act));
      end
   endtask

   task automatic check_apb_addr(input string test, input soc_pkg::apb_addr_t exp,
                                 input soc_pkg::apb_addr_t act);
      if (act !== exp) begin
         fail_run($sformatf("[FAIL] %s: expected %h, actual %h", test, exp, act));
      end
   endtask

   task automatic check_apb_data(input string test, input soc_pkg::apb_data_t exp,
                                 input soc_pkg::apb_data_t act);
      if (act !== exp) begin
         fail_run($sformatf("[FAIL] %s: expected %h, actual %h", test, exp, act));
      end
   endtask

   task automatic check_flag(input string test, input logic exp, input logic act);
      if (act !== exp) begin
         fail_run($sformatf("[FAIL] %s: expected %b, actual %b", test, exp, act));
      end
   endtask

   // One Wishbone classic cycle sampled mid-cycle before the rising edge
   task automatic bus_access(input string test, input soc_pkg::addr_t adr, input logic we,
                             input soc_pkg::data_t wdat,
                             input logic [soc_pkg::NrMemPorts-1:0] cyc_exp,
                             input logic apb_exp, output soc_pkg::data_t rdat,
                             output logic ack, output logic err);
      int   cycles;
      logic done;
      logic psel_prev;
      @(negedge clk);
      host_cyc_i = 1'b1;
      host_stb_i = 1'b1;
      host_we_i  = we;
      host_adr_i = adr;
      host_dat_i = wdat;
      host_sel_i = '1;
      cycles    = 0;
      done      = 1'b0;
      psel_prev = 1'b0;
      apb_seen  = 1'b0;
      while (!done) begin
         #5;
         for (int i = 0; i < soc_pkg::NrMemPorts; i++) begin
            check_flag($sformatf("%s mem_cyc[%0d]", test, i), cyc_exp[i], mem_cyc_o[i]);
            check_flag($sformatf("%s mem_stb[%0d]", test, i), cyc_exp[i], mem_stb_o[i]);
         end
         if (|cyc_exp) begin
            check_addr({test, " mem_adr"}, adr, mem_adr_o);
            check_flag({test, " mem_we"}, we, mem_we_o);
         end
         if (!apb_exp) begin
            check_flag({test, " psel"}, 1'b0, psel_o);
         end
         check_flag({test, " penable"}, psel_o && psel_prev, penable_o);
         if (psel_o) begin
            check_flag({test, " pwrite"}, we, pwrite_o);
            apb_seen       = 1'b1;
            apb_addr_seen  = paddr_o;
            apb_wdata_seen = pwdata_o;
         end
         psel_prev = psel_o;
         if (host_ack_o && host_err_o) begin
            fail_run($sformatf("%s: ack and err were both high", test));
         end
         if (host_ack_o || host_err_o) begin
            done = 1'b1;
            rdat = host_dat_o;
            ack  = host_ack_o;
            err  = host_err_o;
         end else begin
            cycles++;
            if (cycles > MaxWait) begin
               fail_run($sformatf("%s: no ack or err after %0d cycles", test, MaxWait));
            end
            @(negedge clk);
         end
      end
      @(negedge clk);
      host_cyc_i = 1'b0;
      host_stb_i = 1'b0;
      host_we_i  = 1'b0;
   endtask

   // ------------------------------------------------
   // Directed tests
   // ------------------------------------------------
   task automatic reset_values();
      check_flag("reset host_ack", 1'b0, host_ack_o);
      check_flag("reset host_err", 1'b0, host_err_o);
      for (int i = 0; i < soc_pkg::NrMemPorts; i++) begin
         check_flag($sformatf("reset mem_cyc[%0d]", i), 1'b0, mem_cyc_o[i]);
      end
      check_flag("reset psel", 1'b0, psel_o);
      check_flag("reset penable", 1'b0, penable_o);
   endtask

   task automatic mem_write_read();
      soc_pkg::slave_idx_e            slot [soc_pkg::NrMemPorts];
      logic [soc_pkg::NrMemPorts-1:0] mask;
      soc_pkg::addr_t                 adr;
      soc_pkg::data_t                 wdat;
      soc_pkg::data_t                 rdat;
      logic                           ack;
      logic                           err;
      string                          name;
      slot[0] = soc_pkg::ROM;
      slot[1] = soc_pkg::CLINT;
      slot[2] = soc_pkg::SLM;
      slot[3] = soc_pkg::DRAM;
      for (int m = 0; m < soc_pkg::NrMemPorts; m++) begin
         mask    = '0;
         mask[m] = 1'b1;
         adr  = soc_pkg::SlaveBase[slot[m]] + soc_pkg::addr_t'(rand_bits(16) & 32'hfff8);
         wdat = {rand_bits(32), rand_bits(32)};
         name = $sformatf("mem port %0d write", m);
         bus_access(name, adr, 1'b1, wdat, mask, 1'b0, rdat, ack, err);
         check_flag({name, " ack"}, 1'b1, ack);
         check_data({name, " stored data"}, wdat, models_i.last_wdat[m]);
         check_sel({name, " stored sel"}, 8'hff, models_i.last_sel[m]);
         name = $sformatf("mem port %0d read", m);
         bus_access(name, adr, 1'b0, '0, mask, 1'b0, rdat, ack, err);
         check_flag({name, " ack"}, 1'b1, ack);
         check_data({name, " data"}, wdat, rdat);
      end
   endtask

   task automatic unmapped_access();
      soc_pkg::data_t rdat;
      logic           ack;
      logic           err;
      bus_access("unmapped", 64'h3000_0000, 1'b1, 64'h1234, '0, 1'b0, rdat, ack, err);
      check_flag("unmapped err", 1'b1, err);
   endtask

   task automatic apb_write_lanes();
      soc_pkg::data_t wdat;
      soc_pkg::data_t rdat;
      logic           ack;
      logic           err;
      wdat = {rand_bits(32), rand_bits(32)};
      apb_lo_word = wdat[31:0];
      bus_access("apb write lo", 64'h6000_0010, 1'b1, wdat, '0, 1'b1, rdat, ack, err);
      check_flag("apb write lo ack", 1'b1, ack);
      check_flag("apb write lo psel", 1'b1, apb_seen);
      check_apb_addr("apb write lo paddr", 32'h6000_0010, apb_addr_seen);
      check_apb_data("apb write lo pwdata", wdat[31:0], apb_wdata_seen);
      wdat = {rand_bits(32), rand_bits(32)};
      apb_hi_word = wdat[63:32];
      bus_access("apb write hi", 64'h6000_0014, 1'b1, wdat, '0, 1'b1, rdat, ack, err);
      check_flag("apb write hi ack", 1'b1, ack);
      check_apb_addr("apb write hi paddr", 32'h6000_0014, apb_addr_seen);
      check_apb_data("apb write hi pwdata", wdat[63:32], apb_wdata_seen);
   endtask

   task automatic apb_read_lanes();
      soc_pkg::data_t rdat;
      logic           ack;
      logic           err;
      // Repeated so the random pready stalls vary
      for (int n = 0; n < 3; n++) begin
         bus_access("apb read lo", 64'h6000_0010, 1'b0, '0, '0, 1'b1, rdat, ack, err);
         check_flag("apb read lo ack", 1'b1, ack);
         check_data("apb read lo data", {32'h0, apb_lo_word}, rdat);
         bus_access("apb read hi", 64'h6000_0014, 1'b0, '0, '0, 1'b1, rdat, ack, err);
         check_flag("apb read hi ack", 1'b1, ack);
         check_data("apb read hi data", {apb_hi_word, 32'h0}, rdat);
      end
   endtask

   task automatic apb_slave_error();
      soc_pkg::data_t rdat;
      logic           ack;
      logic           err;
      bus_access("apb slverr", 64'h6000_0ffc, 1'b1, 64'h55, '0, 1'b1, rdat, ack, err);
      check_flag("apb slverr err", 1'b1, err);
      check_apb_addr("apb slverr paddr", 32'h6000_0ffc, apb_addr_seen);
   endtask

   // ------------------------------------------------
   // Main sequence and watchdog
   // ------------------------------------------------
   initial begin
      rst_n_i    = 1'b0;
      host_cyc_i = 1'b0;
      host_stb_i = 1'b0;
      host_we_i  = 1'b0;
      host_adr_i = '0;
      host_dat_i = '0;
      host_sel_i = '0;
      repeat (ResetCycles) @(posedge clk);
      @(negedge clk);
      rst_n_i = 1'b1;
      #5;
      reset_values();
      mem_write_read();
      unmapped_access();
      apb_write_lanes();
      apb_read_lanes();
      apb_slave_error();
      $display("SIMULATION PASSED");
      $finish;
   end

   initial begin
      #((ResetCycles + NrTests * WorstCycles) * ClkPeriod);
      fail_run("Run hung, the watchdog expired before the tests finished");
   end

endmodule

`default_nettype wire

/* verification/tb_target_models.sv */
// ------------------------------------------------
// Behavioral memory targets and APB register file
// with random wait states
// ------------------------------------------------
`default_nettype none

module tb_target_models (
   input  logic                           clk,
   // Memory targets, mem_idx_e order
   input  logic [soc_pkg::NrMemPorts-1:0] mem_cyc_i,
   input  logic [soc_pkg::NrMemPorts-1:0] mem_stb_i,
   input  logic                           mem_we_i,
   input  soc_pkg::addr_t                 mem_adr_i,
   input  soc_pkg::data_t                 mem_dat_i,
   input  soc_pkg::sel_t                  mem_sel_i,
   output soc_pkg::data_t                 mem_dat_o [soc_pkg::NrMemPorts],
   output logic [soc_pkg::NrMemPorts-1:0] mem_ack_o,
   output logic [soc_pkg::NrMemPorts-1:0] mem_err_o,
   // APB slave
   input  logic                           psel_i,
   input  logic                           penable_i,
   input  logic                           pwrite_i,
   input  soc_pkg::apb_addr_t             paddr_i,
   input  soc_pkg::apb_data_t             pwdata_i,
   output soc_pkg::apb_data_t             prdata_o,
   output logic                           pready_o,
   output logic                           pslverr_o
);
   timeunit 1ns;
   timeprecision 100ps;

   soc_pkg::data_t                 mem [soc_pkg::NrMemPorts][16];
   soc_pkg::data_t                 last_wdat [soc_pkg::NrMemPorts];
   soc_pkg::sel_t                  last_sel [soc_pkg::NrMemPorts];
   soc_pkg::apb_data_t             regs [64];
   logic [31:0]                    lfsr_q = 32'hea3c;
   logic [soc_pkg::NrMemPorts-1:0] req_q = '0;
   logic [soc_pkg::NrMemPorts-1:0] busy = '0;
   int                             mem_wait [soc_pkg::NrMemPorts];
   int                             apb_wait = 0;

   // Fibonacci LFSR, taps 32 22 2 1, one step per bit
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] r;
      logic        fb;
      r = '0;
      for (int i = 0; i < n; i++) begin
         fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
         lfsr_q = {lfsr_q[30:0], fb};
         r = {r[30:0], fb};
      end
      return r;
   endfunction

   initial begin
      mem_ack_o = '0;
      mem_err_o = '0;
      prdata_o  = '0;
      pready_o  = 1'b0;
      pslverr_o = 1'b0;
      for (int p = 0; p < soc_pkg::NrMemPorts; p++) begin
         mem_dat_o[p] = '0;
         mem_wait[p]  = 0;
      end
   end

   // Requests change on the falling edge, so take them at the rising one
   always @(posedge clk) begin
      req_q <= mem_cyc_i & mem_stb_i;
   end

   always @(negedge clk) begin
      // ------------------------------------------------
      // Memory ports
      // ------------------------------------------------
      for (int p = 0; p < soc_pkg::NrMemPorts; p++) begin
         if (mem_ack_o[p]) begin
            mem_ack_o[p] = 1'b0;
         end else if (req_q[p]) begin
            if (!busy[p]) begin
               busy[p]     = 1'b1;
               mem_wait[p] = int'(rand_bits(2));
            end
            if (mem_wait[p] == 0) begin
               busy[p]      = 1'b0;
               mem_ack_o[p] = 1'b1;
               if (mem_we_i) begin
                  mem[p][mem_adr_i[6:3]] = mem_dat_i;
                  last_wdat[p]           = mem_dat_i;
                  last_sel[p]            = mem_sel_i;
               end
               mem_dat_o[p] = mem[p][mem_adr_i[6:3]];
            end else begin
               mem_wait[p]--;
            end
         end
      end

      // ------------------------------------------------
      // APB slave
      // ------------------------------------------------
      pready_o  = 1'b0;
      pslverr_o = 1'b0;
      if (psel_i && !penable_i) begin
         apb_wait = int'(rand_bits(2));
      end else if (psel_i && penable_i) begin
         if (apb_wait == 0) begin
            pready_o = 1'b1;
            if (paddr_i[11:0] == 12'hffc) begin
               pslverr_o = 1'b1;
            end else if (pwrite_i) begin
               regs[paddr_i[7:2]] = pwdata_i;
            end else begin
               prdata_o = regs[paddr_i[7:2]];
            end
         end else begin
            apb_wait--;
         end
      end
   end

endmodule

`default_nettype wire
